// ==== vlog.f ====
logic/periph_bus_pkg.sv
logic/periph_regs_pkg.sv
logic/periph_reg_bridge.sv
logic/periph_timer.sv
logic/periph_plic.sv
logic/peripheral_subsystem.sv
testbench/peripheral_subsystem_props.sv
testbench/tb_peripheral_subsystem.sv

// ==== testbench/tb_peripheral_subsystem.sv ====
// ################################################
// Peripheral subsystem testbench
// Register table, timer expiry and interrupt claim checks
// ################################################

`timescale 1ns/1ps

module tb_peripheral_subsystem;

  localparam int NUM_TIMERS = 2;
  localparam int NEXT_INT   = 4;
  localparam int NSRC       = NUM_TIMERS + NEXT_INT + 1;
  localparam int TIMEOUT    = 200;

  // Block k sits at k * 256, unmapped block 3 behind the timers
  localparam logic [31:0] PLIC_BASE = 32'h000;
  localparam logic [31:0] T0_BASE   = 32'h100;
  localparam logic [31:0] T1_BASE   = 32'h200;
  localparam logic [31:0] UNMAPPED  = 32'h300;

  typedef struct packed {
    periph_bus_pkg::bus_op_e op;
    logic [31:0]             addr;
    logic [31:0]             wdata;
    logic [31:0]             exp;
  } entry_t;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  req_i;
  logic                  we_i;
  logic [31:0]           addr_i;
  logic [31:0]           wdata_i;
  logic [NEXT_INT-1:0]   intr_ext_i;
  logic                  gnt_o;
  logic                  rvalid_o;
  logic [31:0]           rdata_o;
  logic                  irq_o;
  logic                  msip_o;
  logic [NUM_TIMERS-1:0] timer_intr_o;

  entry_t      table_q[$];
  logic [31:0] rd;

  peripheral_subsystem #(
    .NUM_TIMERS(NUM_TIMERS),
    .NEXT_INT  (NEXT_INT)
  ) peripheral_subsystem_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic stop_on_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  always @(posedge clk_i) begin
    if (peripheral_subsystem_i.props_i.fail_count != 0) begin
      $display("Bus assertion failed, see the error above");
      stop_on_failure();
    end
  end

  // Entered and left 2 ns after a rising edge
  task automatic bus_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited  = 0;
    req_i   = 1'b1;
    we_i    = write;
    addr_i  = addr;
    wdata_i = wdata;
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    while (!rvalid_o) begin
      if (waited == TIMEOUT) begin
        $display("Timeout: no rvalid_o arrived after a bus request");
        stop_on_failure();
      end
      @(posedge clk_i);
      #2;
      waited++;
    end
    rdata = rdata_o;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] resp;
    bus_access(1'b1, addr, data, resp);
    check_value("write response data", 32'h0, resp);
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] expected);
    logic [31:0] resp;
    bus_access(1'b0, addr, 32'h0, resp);
    check_value(name, expected, resp);
  endtask

  task automatic poll_status(input logic [31:0] addr);
    logic [31:0] resp;
    int          polls;
    polls = 0;
    resp  = '0;
    while (!resp[0]) begin
      if (polls == TIMEOUT) begin
        $display("Timeout: timer STATUS expired bit never set");
        stop_on_failure();
      end
      bus_access(1'b0, addr, 32'h0, resp);
      polls++;
    end
  endtask

  task automatic wait_irq();
    int waited;
    waited = 0;
    while (!irq_o) begin
      if (waited == TIMEOUT) begin
        $display("Timeout: irq_o never went high");
        stop_on_failure();
      end
      @(posedge clk_i);
      #2;
      waited++;
    end
  endtask

  task automatic add_entry(input periph_bus_pkg::bus_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] expected);
    table_q.push_back('{op, addr, wdata, expected});
  endtask

  initial begin
    logic [31:0] cmp0;
    logic [31:0] cmp1;
    logic [31:0] ena;
    entry_t      e;
    arst_n_i   = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    intr_ext_i = '0;
    void'($urandom(6493));
    cmp0 = $urandom();
    cmp1 = $urandom();
    ena  = $urandom() & ((32'h1 << NSRC) - 1);
    repeat (5) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;

    check_value("reset rvalid_o", 32'h0, rvalid_o);
    check_value("reset irq_o", 32'h0, irq_o);
    check_value("reset msip_o", 32'h0, msip_o);
    check_value("reset timer_intr_o", 32'h0, timer_intr_o);

    // Reset values of every register
    for (int b = 0; b <= NUM_TIMERS; b++) begin
      for (int o = 0; o < 16; o += 4) begin
        add_entry(periph_bus_pkg::OP_READ, b * 256 + o, 32'h0, 32'h0);
      end
    end
    add_entry(periph_bus_pkg::OP_WRITE, T0_BASE + periph_regs_pkg::TMR_CTRL, 32'h2, 32'h0);
    add_entry(periph_bus_pkg::OP_READ, T0_BASE + periph_regs_pkg::TMR_CTRL, 32'h0, 32'h2);
    add_entry(periph_bus_pkg::OP_WRITE, T0_BASE + periph_regs_pkg::TMR_COMPARE, cmp0, 32'h0);
    add_entry(periph_bus_pkg::OP_READ, T0_BASE + periph_regs_pkg::TMR_COMPARE, 32'h0, cmp0);
    add_entry(periph_bus_pkg::OP_WRITE, T1_BASE + periph_regs_pkg::TMR_COMPARE, cmp1, 32'h0);
    add_entry(periph_bus_pkg::OP_READ, T1_BASE + periph_regs_pkg::TMR_COMPARE, 32'h0, cmp1);
    add_entry(periph_bus_pkg::OP_WRITE, PLIC_BASE + periph_regs_pkg::PLIC_ENABLE, ena, 32'h0);
    add_entry(periph_bus_pkg::OP_READ, PLIC_BASE + periph_regs_pkg::PLIC_ENABLE, 32'h0, ena);
    add_entry(periph_bus_pkg::OP_WRITE, PLIC_BASE + periph_regs_pkg::PLIC_MSIP, 32'h1, 32'h0);
    add_entry(periph_bus_pkg::OP_READ, PLIC_BASE + periph_regs_pkg::PLIC_MSIP, 32'h0, 32'h1);
    // Unmapped block, offset 0 must not reach CTRL or ENABLE
    add_entry(periph_bus_pkg::OP_WRITE, UNMAPPED, 32'hFFFF_FFFF, 32'h0);
    add_entry(periph_bus_pkg::OP_READ, UNMAPPED, 32'h0, 32'h0);
    add_entry(periph_bus_pkg::OP_READ, T0_BASE + periph_regs_pkg::TMR_CTRL, 32'h0, 32'h2);
    add_entry(periph_bus_pkg::OP_READ, PLIC_BASE + periph_regs_pkg::PLIC_ENABLE, 32'h0, ena);

    foreach (table_q[i]) begin
      e = table_q[i];
      bus_access(e.op == periph_bus_pkg::OP_WRITE, e.addr, e.wdata, rd);
      check_value($sformatf("table entry %0d", i), e.exp, rd);
    end
    check_value("msip_o set", 32'h1, msip_o);
    write_reg(PLIC_BASE + periph_regs_pkg::PLIC_MSIP, 32'h0);
    check_value("msip_o cleared", 32'h0, msip_o);

    // Timer 0 with IE, timer 1 without
    write_reg(T0_BASE + periph_regs_pkg::TMR_COMPARE, 32'd12);
    write_reg(T0_BASE + periph_regs_pkg::TMR_CTRL, 32'h3);
    poll_status(T0_BASE + periph_regs_pkg::TMR_STATUS);
    check_value("timer 0 expiry interrupt", 32'h1, timer_intr_o);
    write_reg(T0_BASE + periph_regs_pkg::TMR_CTRL, 32'h2);
    write_reg(T0_BASE + periph_regs_pkg::TMR_STATUS, 32'h1);
    read_check("timer 0 status cleared", T0_BASE + periph_regs_pkg::TMR_STATUS, 32'h0);
    check_value("timer 0 interrupt cleared", 32'h0, timer_intr_o);
    write_reg(T1_BASE + periph_regs_pkg::TMR_COMPARE, 32'd8);
    write_reg(T1_BASE + periph_regs_pkg::TMR_CTRL, 32'h1);
    poll_status(T1_BASE + periph_regs_pkg::TMR_STATUS);
    check_value("timer 1 masked interrupt", 32'h0, timer_intr_o);
    write_reg(T1_BASE + periph_regs_pkg::TMR_CTRL, 32'h0);
    write_reg(T1_BASE + periph_regs_pkg::TMR_STATUS, 32'h1);

    // Timer 0 left its gateway pending, drain it through a claim
    write_reg(PLIC_BASE + periph_regs_pkg::PLIC_ENABLE, 32'h1 << 1);
    read_check("timer 0 claim", PLIC_BASE + periph_regs_pkg::PLIC_CLAIM, 32'd1);
    write_reg(PLIC_BASE + periph_regs_pkg::PLIC_CLAIM, 32'd1);
    read_check("pending after timer claim", PLIC_BASE + periph_regs_pkg::PLIC_PENDING, 32'h0);
    check_value("irq_o after timer claim", 32'h0, irq_o);

    // External lines 0 and 2 are IDs 3 and 5
    write_reg(PLIC_BASE + periph_regs_pkg::PLIC_ENABLE, (32'h1 << 3) | (32'h1 << 5));
    intr_ext_i = 4'b0101;
    wait_irq();
    read_check("first claim", PLIC_BASE + periph_regs_pkg::PLIC_CLAIM, NUM_TIMERS + 1);
    read_check("second claim", PLIC_BASE + periph_regs_pkg::PLIC_CLAIM, NUM_TIMERS + 3);
    intr_ext_i = '0;
    write_reg(PLIC_BASE + periph_regs_pkg::PLIC_CLAIM, NUM_TIMERS + 1);
    write_reg(PLIC_BASE + periph_regs_pkg::PLIC_CLAIM, NUM_TIMERS + 3);
    check_value("irq_o after complete", 32'h0, irq_o);
    read_check("pending after complete", PLIC_BASE + periph_regs_pkg::PLIC_PENDING, 32'h0);

    // Both gateways take a new request once completed
    intr_ext_i = 4'b0101;
    wait_irq();
    intr_ext_i = '0;
    read_check("claim after complete", PLIC_BASE + periph_regs_pkg::PLIC_CLAIM,
               NUM_TIMERS + 1);
    read_check("second claim after complete", PLIC_BASE + periph_regs_pkg::PLIC_CLAIM,
               NUM_TIMERS + 3);
    write_reg(PLIC_BASE + periph_regs_pkg::PLIC_CLAIM, NUM_TIMERS + 1);
    write_reg(PLIC_BASE + periph_regs_pkg::PLIC_CLAIM, NUM_TIMERS + 3);

    // Line 1 raised while only ID 3 is enabled
    write_reg(PLIC_BASE + periph_regs_pkg::PLIC_ENABLE, 32'h1 << 3);
    intr_ext_i = 4'b0010;
    @(posedge clk_i);
    #2;
    read_check("disabled source pending", PLIC_BASE + periph_regs_pkg::PLIC_PENDING, 32'h10);
    check_value("irq_o for disabled source", 32'h0, irq_o);
    read_check("claim of disabled source", PLIC_BASE + periph_regs_pkg::PLIC_CLAIM, 32'h0);
    read_check("disabled source still pending",
               PLIC_BASE + periph_regs_pkg::PLIC_PENDING, 32'h10);
    intr_ext_i = '0;

    if (peripheral_subsystem_i.props_i.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("Bus assertions failed %0d times", peripheral_subsystem_i.props_i.fail_count);
      stop_on_failure();
    end
  end

endmodule : tb_peripheral_subsystem

// ==== testbench/peripheral_subsystem_props.sv ====
// ################################################
// Bus timing and decode assertions
// ################################################

`timescale 1ns/1ps

module peripheral_subsystem_props #(
  parameter int NUM_TIMERS = 2
) (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic                  req_i,
  input logic                  gnt_i,
  input logic                  rvalid_i,
  input logic [NUM_TIMERS-1:0] tmr_sel_i,
  input logic                  plic_sel_i
);

  int fail_count = 0;

  a_gnt_is_req: assert property (@(posedge clk_i) disable iff (!arst_n_i) gnt_i == req_i)
    else begin
      fail_count++;
      $error("gnt_o differs from req_i");
    end

  // Response exactly one cycle after each grant
  a_rvalid_delay: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_i == $past(gnt_i))
    else begin
      fail_count++;
      $error("rvalid_o does not follow the grant by one cycle");
    end

  a_sel_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(tmr_sel_i) && !(plic_sel_i && |tmr_sel_i))
    else begin
      fail_count++;
      $error("more than one block selected");
    end

endmodule : peripheral_subsystem_props

bind peripheral_subsystem peripheral_subsystem_props #(
  .NUM_TIMERS(NUM_TIMERS)
) props_i (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .req_i     (req_i),
  .gnt_i     (gnt_o),
  .rvalid_i  (rvalid_o),
  .tmr_sel_i (tmr_sel),
  .plic_sel_i(plic_sel)
);

// ==== logic/peripheral_subsystem.sv ====
// ################################################
// Peripheral subsystem top
// Bridge, timer channels and interrupt controller
// ################################################

`timescale 1ns/1ps

module peripheral_subsystem #(
  parameter int NUM_TIMERS = 2,
  parameter int NEXT_INT   = 4
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [periph_bus_pkg::DATA_W-1:0] addr_i,
  input  logic [periph_bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [NEXT_INT-1:0]               intr_ext_i,
  output logic                              gnt_o,
  output logic                              rvalid_o,
  output logic [periph_bus_pkg::DATA_W-1:0] rdata_o,
  output logic                              irq_o,
  output logic                              msip_o,
  output logic [NUM_TIMERS-1:0]             timer_intr_o
);

  localparam int DW = periph_bus_pkg::DATA_W;

  logic [NUM_TIMERS-1:0]              tmr_sel;
  logic                               plic_sel;
  logic                               reg_we;
  logic [periph_bus_pkg::BLK_LSB-1:0] reg_off;
  logic [DW-1:0]                      reg_wdata;
  logic [NUM_TIMERS*DW-1:0]           tmr_rdata;
  logic [DW-1:0]                      plic_rdata;
  logic [NUM_TIMERS-1:0]              tmr_intr;

  periph_reg_bridge #(
    .NUM_TIMERS(NUM_TIMERS)
  ) periph_reg_bridge_i (
    .clk_i,
    .arst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .tmr_sel_o   (tmr_sel),
    .plic_sel_o  (plic_sel),
    .reg_we_o    (reg_we),
    .reg_off_o   (reg_off),
    .reg_wdata_o (reg_wdata),
    .tmr_rdata_i (tmr_rdata),
    .plic_rdata_i(plic_rdata)
  );

  for (genvar k = 0; k < NUM_TIMERS; k++) begin : g_timer
    periph_timer periph_timer_i (
      .clk_i,
      .arst_n_i,
      .sel_i  (tmr_sel[k]),
      .we_i   (reg_we),
      .off_i  (reg_off),
      .wdata_i(reg_wdata),
      .rdata_o(tmr_rdata[k*DW +: DW]),
      .intr_o (tmr_intr[k])
    );
  end

  periph_plic #(
    .NUM_TIMERS(NUM_TIMERS),
    .NEXT_INT  (NEXT_INT)
  ) periph_plic_i (
    .clk_i,
    .arst_n_i,
    .sel_i     (plic_sel),
    .we_i      (reg_we),
    .off_i     (reg_off),
    .wdata_i   (reg_wdata),
    .tmr_intr_i(tmr_intr),
    .intr_ext_i,
    .rdata_o   (plic_rdata),
    .irq_o,
    .msip_o
  );

  assign timer_intr_o = tmr_intr;

endmodule : peripheral_subsystem

// ==== logic/periph_plic.sv ====
// ################################################
// Platform interrupt controller
// Gateways, enables, claim/complete and MSIP bit
// ################################################

`timescale 1ns/1ps

module periph_plic #(
  parameter int NUM_TIMERS = 2,
  parameter int NEXT_INT   = 4
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               sel_i,
  input  logic                               we_i,
  input  logic [periph_bus_pkg::BLK_LSB-1:0] off_i,
  input  logic [periph_bus_pkg::DATA_W-1:0]  wdata_i,
  input  logic [NUM_TIMERS-1:0]              tmr_intr_i,
  input  logic [NEXT_INT-1:0]                intr_ext_i,
  output logic [periph_bus_pkg::DATA_W-1:0]  rdata_o,
  output logic                               irq_o,
  output logic                               msip_o
);

  localparam int NSRC = NUM_TIMERS + NEXT_INT + 1;
  localparam int ID_W = $clog2(NSRC);

  logic [NSRC-1:0]            src;
  logic [NSRC-1:0]            pending;
  logic [NSRC-1:0]            pending_d;
  logic [NSRC-1:0]            enable_q;
  logic [NSRC-1:0]            enable_d;
  logic [ID_W-1:0]            claim_id;
  logic                       claim_rd;
  logic                       complete_wr;
  logic                       msip_q;
  logic                       irq_q;
  periph_regs_pkg::gw_state_e gw_q [NSRC];
  periph_regs_pkg::gw_state_e gw_d [NSRC];

  // ID 0 means no interrupt and stays low
  assign src = {intr_ext_i, tmr_intr_i, 1'b0};

  assign claim_rd    = sel_i && !we_i && (off_i == periph_regs_pkg::PLIC_CLAIM);
  assign complete_wr = sel_i && we_i && (off_i == periph_regs_pkg::PLIC_CLAIM);

  assign enable_d = (sel_i && we_i && off_i == periph_regs_pkg::PLIC_ENABLE) ?
                    wdata_i[NSRC-1:0] : enable_q;

  // Lowest ID wins, the loop runs downward so the last hit is kept
  always_comb begin
    claim_id = '0;
    for (int i = NSRC - 1; i > 0; i--) begin
      if (pending[i] && enable_q[i]) begin
        claim_id = ID_W'(i);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NSRC; i++) begin
      gw_d[i] = gw_q[i];
      case (gw_q[i])
        periph_regs_pkg::GW_IDLE: begin
          if (src[i]) gw_d[i] = periph_regs_pkg::GW_PENDING;
        end
        periph_regs_pkg::GW_PENDING: begin
          if (claim_rd && claim_id == i) gw_d[i] = periph_regs_pkg::GW_ACTIVE;
        end
        periph_regs_pkg::GW_ACTIVE: begin
          if (complete_wr && wdata_i == i) gw_d[i] = periph_regs_pkg::GW_IDLE;
        end
        default: gw_d[i] = periph_regs_pkg::GW_IDLE;
      endcase
      pending[i]   = (gw_q[i] == periph_regs_pkg::GW_PENDING);
      pending_d[i] = (gw_d[i] == periph_regs_pkg::GW_PENDING);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NSRC; i++) begin
        gw_q[i] <= periph_regs_pkg::GW_IDLE;
      end
      enable_q <= '0;
      msip_q   <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      gw_q     <= gw_d;
      enable_q <= enable_d;
      if (sel_i && we_i && off_i == periph_regs_pkg::PLIC_MSIP) begin
        msip_q <= wdata_i[0];
      end
      // Built from next state so a raised line shows after one edge
      irq_q <= |(pending_d & enable_d);
    end
  end

  always_comb begin
    rdata_o = '0;
    case (off_i)
      periph_regs_pkg::PLIC_ENABLE:  rdata_o[NSRC-1:0] = enable_q;
      periph_regs_pkg::PLIC_PENDING: rdata_o[NSRC-1:0] = pending;
      periph_regs_pkg::PLIC_CLAIM:   rdata_o[ID_W-1:0] = claim_id;
      periph_regs_pkg::PLIC_MSIP:    rdata_o[0] = msip_q;
      default:                       rdata_o = '0;
    endcase
  end

  assign irq_o  = irq_q;
  assign msip_o = msip_q;

endmodule : periph_plic

// ==== logic/periph_timer.sv ====
// ################################################
// Periodic compare timer channel
// ################################################

`timescale 1ns/1ps

module periph_timer (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               sel_i,
  input  logic                               we_i,
  input  logic [periph_bus_pkg::BLK_LSB-1:0] off_i,
  input  logic [periph_bus_pkg::DATA_W-1:0]  wdata_i,
  output logic [periph_bus_pkg::DATA_W-1:0]  rdata_o,
  output logic                               intr_o
);

  localparam int EN = periph_regs_pkg::CTRL_EN_BIT;
  localparam int IE = periph_regs_pkg::CTRL_IE_BIT;

  logic [1:0]                              ctrl_q;
  logic [periph_bus_pkg::DATA_W-1:0]       count_q;
  logic [periph_bus_pkg::DATA_W-1:0]       compare_q;
  logic                                    status_q;
  logic                                    wr;
  logic                                    hit;
  logic                                    status_clr;

  assign wr         = sel_i && we_i;
  assign hit        = ctrl_q[EN] && (count_q == compare_q);
  assign status_clr = wr && (off_i == periph_regs_pkg::TMR_STATUS) && wdata_i[0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q    <= '0;
      count_q   <= '0;
      compare_q <= '0;
      status_q  <= 1'b0;
    end else begin
      if (wr && off_i == periph_regs_pkg::TMR_CTRL) begin
        ctrl_q[EN] <= wdata_i[EN];
        ctrl_q[IE] <= wdata_i[IE];
      end
      if (wr && off_i == periph_regs_pkg::TMR_COMPARE) begin
        compare_q <= wdata_i;
      end
      // Bus load takes priority over counting
      if (wr && off_i == periph_regs_pkg::TMR_COUNT) begin
        count_q <= wdata_i;
      end else if (ctrl_q[EN]) begin
        count_q <= hit ? '0 : count_q + 1'b1;
      end
      // A new expiry wins over the clear
      status_q <= hit || (status_q && !status_clr);
    end
  end

  always_comb begin
    rdata_o = '0;
    case (off_i)
      periph_regs_pkg::TMR_CTRL: begin
        rdata_o[EN] = ctrl_q[EN];
        rdata_o[IE] = ctrl_q[IE];
      end
      periph_regs_pkg::TMR_COUNT:   rdata_o = count_q;
      periph_regs_pkg::TMR_COMPARE: rdata_o = compare_q;
      periph_regs_pkg::TMR_STATUS:  rdata_o[0] = status_q;
      default:                      rdata_o = '0;
    endcase
  end

  assign intr_o = status_q && ctrl_q[IE];

endmodule : periph_timer

// ==== logic/periph_reg_bridge.sv ====
// ################################################
// Bus to register bridge
// Block decode, read mux and one-cycle response
// ################################################

`timescale 1ns/1ps

module periph_reg_bridge #(
  parameter int NUM_TIMERS = 2
) (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,

  // Core side
  input  logic                                         req_i,
  input  logic                                         we_i,
  input  logic [periph_bus_pkg::DATA_W-1:0]            addr_i,
  input  logic [periph_bus_pkg::DATA_W-1:0]            wdata_i,
  output logic                                         gnt_o,
  output logic                                         rvalid_o,
  output logic [periph_bus_pkg::DATA_W-1:0]            rdata_o,

  // Register side
  output logic [NUM_TIMERS-1:0]                        tmr_sel_o,
  output logic                                         plic_sel_o,
  output logic                                         reg_we_o,
  output logic [periph_bus_pkg::BLK_LSB-1:0]           reg_off_o,
  output logic [periph_bus_pkg::DATA_W-1:0]            reg_wdata_o,
  input  logic [NUM_TIMERS*periph_bus_pkg::DATA_W-1:0] tmr_rdata_i,
  input  logic [periph_bus_pkg::DATA_W-1:0]            plic_rdata_i
);

  localparam int DW = periph_bus_pkg::DATA_W;

  logic [periph_bus_pkg::BLK_W-1:0] blk;
  logic [DW-1:0]                    rd_word;
  logic                             rvalid_q;
  periph_bus_pkg::bus_op_e          op_q;
  logic [DW-1:0]                    rdata_q;

  // No back-pressure, every request is taken at once
  assign gnt_o = req_i;

  assign blk = addr_i[periph_bus_pkg::BLK_LSB +: periph_bus_pkg::BLK_W];

  assign plic_sel_o = req_i && (blk == periph_bus_pkg::BLK_PLIC);

  for (genvar k = 0; k < NUM_TIMERS; k++) begin : g_tmr_dec
    assign tmr_sel_o[k] = req_i && (blk == periph_bus_pkg::BLK_PLIC + k + 1);
  end

  assign reg_we_o    = we_i;
  assign reg_off_o   = addr_i[periph_bus_pkg::BLK_LSB-1:0];
  assign reg_wdata_o = wdata_i;

  // Unmapped blocks fall through to zero
  always_comb begin
    rd_word = '0;
    if (plic_sel_o) begin
      rd_word = plic_rdata_i;
    end
    for (int k = 0; k < NUM_TIMERS; k++) begin
      if (tmr_sel_o[k]) begin
        rd_word = tmr_rdata_i[k*DW +: DW];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      op_q     <= periph_bus_pkg::OP_READ;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= req_i;
      if (req_i) begin
        op_q    <= we_i ? periph_bus_pkg::OP_WRITE : periph_bus_pkg::OP_READ;
        rdata_q <= rd_word;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  // Writes answer with zero data
  assign rdata_o  = (rvalid_q && op_q == periph_bus_pkg::OP_READ) ? rdata_q : '0;

endmodule : periph_reg_bridge

// ==== logic/periph_regs_pkg.sv ====
// ################################################
// Peripheral register map package
// Timer and interrupt controller offsets and fields
// ################################################

package periph_regs_pkg;

  // Timer channel register offsets
  localparam logic [periph_bus_pkg::BLK_LSB-1:0] TMR_CTRL    = 'h0;
  localparam logic [periph_bus_pkg::BLK_LSB-1:0] TMR_COUNT   = 'h4;
  localparam logic [periph_bus_pkg::BLK_LSB-1:0] TMR_COMPARE = 'h8;
  localparam logic [periph_bus_pkg::BLK_LSB-1:0] TMR_STATUS  = 'hC;

  // Timer CTRL fields
  localparam int CTRL_EN_BIT = 0;
  localparam int CTRL_IE_BIT = 1;

  // Interrupt controller register offsets
  localparam logic [periph_bus_pkg::BLK_LSB-1:0] PLIC_ENABLE  = 'h0;
  localparam logic [periph_bus_pkg::BLK_LSB-1:0] PLIC_PENDING = 'h4;
  localparam logic [periph_bus_pkg::BLK_LSB-1:0] PLIC_CLAIM   = 'h8;
  localparam logic [periph_bus_pkg::BLK_LSB-1:0] PLIC_MSIP    = 'hC;

  // Per-source gateway
  typedef enum logic [1:0] {
    GW_IDLE    = 2'd0,
    GW_PENDING = 2'd1,
    GW_ACTIVE  = 2'd2
  } gw_state_e;

endpackage : periph_regs_pkg

// ==== logic/periph_bus_pkg.sv ====
// ################################################
// Peripheral bus package
// Bus widths, block decode and the response opcode
// ################################################

package periph_bus_pkg;

  // Data and address width of the core-side bus
  localparam int DATA_W = 32;

  // Block select field inside the address.
  // Each block owns 256 bytes of register space
  localparam int BLK_LSB = 8;
  localparam int BLK_W   = 4;

  // Interrupt controller block, timer k sits at block k+1
  localparam int BLK_PLIC = 0;

  // Kind of access held for the response phase
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

endpackage : periph_bus_pkg
